// File: design/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int wordWidth = 32;
    localparam int regIndexWidth = 5;
    localparam int opcodeWidth = 6;
    localparam int functWidth = 6;
    localparam int targetWidth = 26;

    typedef logic [wordWidth-1:0] word_t;
    typedef logic [regIndexWidth-1:0] regIndex_t;
    typedef logic [opcodeWidth-1:0] opcode_t;
    typedef logic [functWidth-1:0] funct_t;

    // Primary opcodes
    localparam opcode_t opSpecial = 6'h00;
    localparam opcode_t opJ = 6'h02;
    localparam opcode_t opJal = 6'h03;
    localparam opcode_t opBeq = 6'h04;
    localparam opcode_t opBne = 6'h05;
    localparam opcode_t opOri = 6'h0d;
    localparam opcode_t opLui = 6'h0f;
    localparam opcode_t opLw = 6'h23;
    localparam opcode_t opSw = 6'h2b;

    // R-type function codes
    localparam funct_t fnJr = 6'h08;
    localparam funct_t fnAddu = 6'h21;
    localparam funct_t fnSubu = 6'h23;
    localparam funct_t fnAnd = 6'h24;
    localparam funct_t fnOr = 6'h25;
    localparam funct_t fnSlt = 6'h2a;

    localparam word_t resetPc = 32'h0000_3000;
    localparam regIndex_t linkReg = 5'd31;

endpackage

`default_nettype wire

// File: design/pipePkg.sv
`default_nettype none

package pipePkg;
    import isaPkg::*;

    typedef logic [2:0] aluOp_t;
    localparam aluOp_t aluAdd = 3'd0;
    localparam aluOp_t aluSub = 3'd1;
    localparam aluOp_t aluAnd = 3'd2;
    localparam aluOp_t aluOr = 3'd3;
    localparam aluOp_t aluSlt = 3'd4;
    localparam aluOp_t aluLui = 3'd5;

    typedef logic [1:0] wbSource_t;
    localparam wbSource_t wbNone = 2'd0;
    localparam wbSource_t wbAlu = 2'd1;
    localparam wbSource_t wbMem = 2'd2;
    localparam wbSource_t wbLink = 2'd3;

    // All zero is a bubble
    typedef struct packed {
        regIndex_t src1;
        regIndex_t src2;
        regIndex_t dest;
        logic src1Early;
        logic src2Early;
        word_t imm;
        logic useImm;
        aluOp_t aluOp;
        wbSource_t wbSrc;
        logic memLoad;
        logic memStore;
        logic branch;
        logic branchNe;
        logic jump;
        logic jumpReg;
        logic [targetWidth-1:0] target26;
    } ctrl_t;

    typedef struct packed {
        logic valid;
        regIndex_t dest;
        word_t value;
    } fwdSource_t;

    // Execute keeps the raw word and decodes it again
    typedef struct packed {
        word_t pc;
        word_t instr;
        word_t op1;
        word_t op2;
    } exStage_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t result;
        word_t storeData;
    } memStage_t;

    typedef struct packed {
        regIndex_t dest;
        word_t result;
    } wbStage_t;

endpackage

`default_nettype wire

// File: design/instructionFetch.sv
`timescale 1ns/1ps
`default_nettype none

module instructionFetch
    import isaPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  stall,
    input  logic  redirect,
    input  word_t target,
    output word_t pc
);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else if (redirect) begin
            pc <= target;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

endmodule

`default_nettype wire

// File: design/instructionDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder
    import isaPkg::*, pipePkg::*;
(
    input  word_t instr,
    output ctrl_t ctrl
);

    opcode_t opcode;
    funct_t funct;
    regIndex_t rs;
    regIndex_t rt;
    regIndex_t rd;
    logic [15:0] imm16;
    logic rAlu;

    assign opcode = instr[31:26];
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];
    assign funct = instr[5:0];
    assign imm16 = instr[15:0];
    assign rAlu = funct inside {fnAddu, fnSubu, fnAnd, fnOr, fnSlt};

    always_comb begin
        ctrl = '0;
        case (opcode)
            opSpecial: begin
                if (funct == fnJr) begin
                    ctrl.src1 = rs;
                    ctrl.src1Early = 1'b1;
                    ctrl.jumpReg = 1'b1;
                end else if (rAlu) begin
                    ctrl.src1 = rs;
                    ctrl.src2 = rt;
                    ctrl.dest = rd;
                    ctrl.wbSrc = wbAlu;
                    case (funct)
                        fnSubu: ctrl.aluOp = aluSub;
                        fnAnd: ctrl.aluOp = aluAnd;
                        fnOr: ctrl.aluOp = aluOr;
                        fnSlt: ctrl.aluOp = aluSlt;
                        default: ctrl.aluOp = aluAdd;
                    endcase
                end
            end
            opOri, opLui: begin
                ctrl.src1 = (opcode == opOri) ? rs : '0;
                ctrl.dest = rt;
                ctrl.imm = {16'h0, imm16};
                ctrl.useImm = 1'b1;
                ctrl.aluOp = (opcode == opOri) ? aluOr : aluLui;
                ctrl.wbSrc = wbAlu;
            end
            opLw, opSw: begin
                ctrl.src1 = rs;
                ctrl.imm = {{16{imm16[15]}}, imm16};
                ctrl.useImm = 1'b1;
                ctrl.aluOp = aluAdd;
                if (opcode == opLw) begin
                    ctrl.dest = rt;
                    ctrl.wbSrc = wbMem;
                    ctrl.memLoad = 1'b1;
                end else begin
                    // Store data rides along in src2
                    ctrl.src2 = rt;
                    ctrl.memStore = 1'b1;
                end
            end
            opBeq, opBne: begin
                ctrl.src1 = rs;
                ctrl.src2 = rt;
                ctrl.src1Early = 1'b1;
                ctrl.src2Early = 1'b1;
                ctrl.imm = {{16{imm16[15]}}, imm16};
                ctrl.branch = 1'b1;
                ctrl.branchNe = (opcode == opBne);
            end
            opJ, opJal: begin
                ctrl.jump = 1'b1;
                ctrl.target26 = instr[targetWidth-1:0];
                if (opcode == opJal) begin
                    ctrl.dest = linkReg;
                    ctrl.wbSrc = wbLink;
                end
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile
    import isaPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  regIndex_t readAddr1,
    input  regIndex_t readAddr2,
    output word_t     readData1,
    output word_t     readData2,
    input  regIndex_t writeAddr,
    input  word_t     writeData
);

    word_t regs [32];

    // Register zero is never written, so it stays cleared
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

endmodule

`default_nettype wire

// File: design/operandForward.sv
`timescale 1ns/1ps
`default_nettype none

module operandForward
    import isaPkg::*, pipePkg::*;
#(
    parameter int srcCount = 3
) (
    input  regIndex_t  request,
    input  word_t      original,
    input  logic       needNow,
    input  fwdSource_t sources [srcCount],
    output word_t      value,
    output logic       mustWait
);

    logic found;

    // Sources come youngest first
    always_comb begin
        value = original;
        mustWait = 1'b0;
        found = 1'b0;
        if (request == '0) begin
            value = '0;
        end else begin
            for (int i = 0; i < srcCount; i++) begin
                if (!found && sources[i].dest == request) begin
                    found = 1'b1;
                    value = sources[i].value;
                    mustWait = needNow && !sources[i].valid;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/pipelineCpu.sv
`timescale 1ns/1ps
`default_nettype none

module pipelineCpu
    import isaPkg::*, pipePkg::*;
(
    input  logic  clk,
    input  logic  reset,
    output word_t imemAddr,
    input  word_t imemData,
    output word_t effectivePc,
    output word_t busAddress,
    output word_t busDataIn,
    input  word_t busDataOut,
    output logic  busRead,
    output logic  busWrite
);

    word_t pc;
    word_t dInstr;
    word_t dPc;
    ctrl_t dCtrl;
    word_t rfData1;
    word_t rfData2;
    word_t dOp1;
    word_t dOp2;
    logic dWait1;
    logic dWait2;
    logic dStall;
    logic redirect;
    word_t target;

    exStage_t ex;
    ctrl_t exCtrl;
    word_t eOp1;
    word_t eOp2;
    logic eWait1;
    logic eWait2;
    logic eStall;
    word_t aluB;
    word_t aluOut;
    word_t linkValue;

    memStage_t mem;
    word_t mStoreData;
    wbStage_t wb;

    fwdSource_t exFwd;
    fwdSource_t memFwd;
    fwdSource_t wbFwd;
    fwdSource_t dSources [3];
    fwdSource_t eSources [2];
    fwdSource_t mSources [1];

    // An execute wait holds decode too
    assign dStall = dWait1 || dWait2 || eStall;
    assign eStall = eWait1 || eWait2;

    instructionFetch fetch_i (
        .clk(clk),
        .reset(reset),
        .stall(dStall),
        .redirect(redirect),
        .target(target),
        .pc(pc)
    );

    assign imemAddr = pc;
    assign effectivePc = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            dInstr <= '0;
        end else if (!dStall) begin
            dInstr <= imemData;
            dPc <= pc;
        end
    end

    instructionDecoder decode_i (
        .instr(dInstr),
        .ctrl(dCtrl)
    );

    registerFile regs_i (
        .clk(clk),
        .reset(reset),
        .readAddr1(dCtrl.src1),
        .readAddr2(dCtrl.src2),
        .readData1(rfData1),
        .readData2(rfData2),
        .writeAddr(wb.dest),
        .writeData(wb.result)
    );

    assign exFwd = '{valid: exCtrl.wbSrc == wbLink, dest: exCtrl.dest, value: linkValue};
    assign memFwd = '{valid: mem.ctrl.wbSrc != wbMem, dest: mem.ctrl.dest, value: mem.result};
    assign wbFwd = '{valid: 1'b1, dest: wb.dest, value: wb.result};
    assign dSources = '{exFwd, memFwd, wbFwd};
    assign eSources = '{memFwd, wbFwd};
    assign mSources = '{wbFwd};

    operandForward #(.srcCount(3)) dFwd1_i (
        .request(dCtrl.src1), .original(rfData1), .needNow(dCtrl.src1Early),
        .sources(dSources), .value(dOp1), .mustWait(dWait1)
    );

    operandForward #(.srcCount(3)) dFwd2_i (
        .request(dCtrl.src2), .original(rfData2), .needNow(dCtrl.src2Early),
        .sources(dSources), .value(dOp2), .mustWait(dWait2)
    );

    // Branches and jumps resolve here, delay slot already in fetch
    always_comb begin
        redirect = 1'b0;
        target = dPc + 32'd4 + {dCtrl.imm[29:0], 2'b00};
        if (dCtrl.branch) begin
            redirect = dCtrl.branchNe ? (dOp1 != dOp2) : (dOp1 == dOp2);
        end else if (dCtrl.jumpReg) begin
            redirect = 1'b1;
            target = dOp1;
        end else if (dCtrl.jump) begin
            redirect = 1'b1;
            target = {dPc[31:28], dCtrl.target26, 2'b00};
        end
        if (dStall) begin
            redirect = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex.instr <= '0;
        end else if (eStall) begin
            // Sources move on while held, so keep the freshest values
            ex.op1 <= eOp1;
            ex.op2 <= eOp2;
        end else begin
            ex.pc <= dPc;
            ex.instr <= dStall ? '0 : dInstr;
            ex.op1 <= dOp1;
            ex.op2 <= dOp2;
        end
    end

    instructionDecoder execDecode_i (
        .instr(ex.instr),
        .ctrl(exCtrl)
    );

    operandForward #(.srcCount(2)) eFwd1_i (
        .request(exCtrl.src1), .original(ex.op1), .needNow(!exCtrl.src1Early),
        .sources(eSources), .value(eOp1), .mustWait(eWait1)
    );

    operandForward #(.srcCount(2)) eFwd2_i (
        .request(exCtrl.src2), .original(ex.op2),
        .needNow(!exCtrl.src2Early && !exCtrl.useImm),
        .sources(eSources), .value(eOp2), .mustWait(eWait2)
    );

    assign aluB = exCtrl.useImm ? exCtrl.imm : eOp2;
    assign linkValue = ex.pc + 32'd8;

    always_comb begin
        case (exCtrl.aluOp)
            aluSub: aluOut = eOp1 - aluB;
            aluAnd: aluOut = eOp1 & aluB;
            aluOr: aluOut = eOp1 | aluB;
            aluSlt: aluOut = {31'h0, $signed(eOp1) < $signed(aluB)};
            aluLui: aluOut = aluB << 16;
            default: aluOut = eOp1 + aluB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || eStall) begin
            mem.ctrl <= '0;
        end else begin
            mem.ctrl <= exCtrl;
            mem.result <= (exCtrl.wbSrc == wbLink) ? linkValue : aluOut;
            mem.storeData <= eOp2;
        end
    end

    // Store data may still be a load landing in write-back
    operandForward #(.srcCount(1)) mFwd_i (
        .request(mem.ctrl.src2), .original(mem.storeData), .needNow(1'b0),
        .sources(mSources), .value(mStoreData), .mustWait()
    );

    assign busAddress = mem.result;
    assign busDataIn = mStoreData;
    assign busWrite = mem.ctrl.memStore;
    assign busRead = mem.ctrl.memLoad;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb.dest <= '0;
        end else begin
            wb.dest <= mem.ctrl.dest;
            wb.result <= mem.ctrl.memLoad ? busDataOut : mem.result;
        end
    end

endmodule

`default_nettype wire

// File: bench/pipelineCpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module pipelineCpuTb
    import isaPkg::*;
;

    localparam int storeTimeout = 200;
    localparam int quietCycles = 40;
    // First sw sits at word 9 and nothing stalls before it
    localparam int firstSwIndex = 9;
    localparam int firstSwCycle = firstSwIndex + 3;

    typedef struct packed {
        int    testNum;
        word_t addr;
        word_t data;
    } expStore_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } storeEvent_t;

    logic  clk = 1'b0;
    logic  reset = 1'b1;
    word_t imemAddr;
    word_t imemData = '0;
    word_t effectivePc;
    word_t busAddress;
    word_t busDataIn;
    word_t busDataOut = '0;
    logic  busRead;
    logic  busWrite;

    word_t progMem [64];
    int progLen;
    word_t dataMem [1024];
    expStore_t expTable [$];
    storeEvent_t storeQ [$];
    string testName [7];
    int testFails [7];
    int checkCount = 0;
    int failCount = 0;
    int cycle = 0;
    int firstStoreCycle = -1;
    word_t firstPc = '0;
    word_t firstEffPc = '0;
    bit strobeInReset = 1'b0;

    pipelineCpu dut_i (
        .clk(clk),
        .reset(reset),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .effectivePc(effectivePc),
        .busAddress(busAddress),
        .busDataIn(busDataIn),
        .busDataOut(busDataOut),
        .busRead(busRead),
        .busWrite(busWrite)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic word_t rTypeWord(regIndex_t rs, regIndex_t rt, regIndex_t rd, funct_t fn);
        return {opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t immWord(opcode_t op, regIndex_t rs, regIndex_t rt,
                                      logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jumpWord(opcode_t op, word_t addr);
        return {op, addr[27:2]};
    endfunction

    // Spread over the whole address so stale reads show up
    function automatic word_t fillWord(word_t addr);
        return (addr * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
    endfunction

    function automatic word_t fetchWord(word_t addr);
        word_t offset;
        offset = addr - resetPc;
        if (offset[1:0] == 2'b00 && (offset >> 2) < progLen) begin
            return progMem[offset[7:2]];
        end
        return '0;
    endfunction

    task automatic appendInstr(input word_t instr);
        progMem[progLen] = instr;
        progLen++;
    endtask

    task automatic addExpect(input int testNum, input word_t addr, input word_t data);
        expTable.push_back('{testNum: testNum, addr: addr, data: data});
    endtask

    task automatic compareWord(input string name, input word_t got, input word_t expected,
                               input int testNum);
        checkCount++;
        assert (got === expected) else begin
            $display("[FAIL] test %0d %s: got %h, expected %h", testNum, name, got, expected);
            failCount++;
            testFails[testNum]++;
        end
    endtask

    task automatic confirm(input bit ok, input string what, input int testNum);
        checkCount++;
        assert (ok) else begin
            $display("Test %0d went wrong: %s", testNum, what);
            failCount++;
            testFails[testNum]++;
        end
    endtask

    task automatic reportTest(input int testNum);
        if (testFails[testNum] == 0) begin
            $display("Test %0d, %s: ok", testNum, testName[testNum]);
        end else begin
            $display("Test %0d, %s: %0d errors", testNum, testName[testNum], testFails[testNum]);
        end
    endtask

    task automatic waitForStore(output bit gotIt);
        int waited;
        waited = 0;
        while (storeQ.size() == 0 && waited < storeTimeout) begin
            @(posedge clk);
            waited++;
        end
        gotIt = (storeQ.size() != 0);
    endtask

    task automatic buildProgram(input word_t a, input word_t b);
        word_t s;
        word_t d;
        word_t n;
        word_t o;
        s = a + b;
        d = a - s;
        n = d & a;
        o = n | b;
        progLen = 0;
        for (int i = 0; i < 64; i++) begin
            progMem[i] = '0;
        end
        // Dependent ALU chain on random constants
        appendInstr(immWord(opLui, 5'd0, 5'd1, a[31:16]));
        appendInstr(immWord(opOri, 5'd1, 5'd1, a[15:0]));
        appendInstr(immWord(opLui, 5'd0, 5'd2, b[31:16]));
        appendInstr(immWord(opOri, 5'd2, 5'd2, b[15:0]));
        appendInstr(rTypeWord(5'd1, 5'd2, 5'd3, fnAddu));
        appendInstr(rTypeWord(5'd1, 5'd3, 5'd4, fnSubu));
        appendInstr(rTypeWord(5'd4, 5'd1, 5'd5, fnAnd));
        appendInstr(rTypeWord(5'd5, 5'd2, 5'd6, fnOr));
        appendInstr(rTypeWord(5'd6, 5'd4, 5'd7, fnSlt));
        for (int r = 3; r <= 7; r++) begin
            appendInstr(immWord(opSw, 5'd0, 5'(r), 16'(32'h100 + (r - 3) * 4)));
        end
        addExpect(1, 32'h100, s);
        addExpect(1, 32'h104, d);
        addExpect(1, 32'h108, n);
        addExpect(1, 32'h10c, o);
        addExpect(1, 32'h110, ($signed(o) < $signed(d)) ? 32'd1 : 32'd0);
        // Load-use
        appendInstr(immWord(opLw, 5'd0, 5'd8, 16'h0200));
        appendInstr(rTypeWord(5'd8, 5'd1, 5'd9, fnAddu));
        appendInstr(immWord(opSw, 5'd0, 5'd9, 16'h0114));
        addExpect(2, 32'h114, fillWord(32'h200) + a);
        // Taken beq to word 23 and a bne falling through to word 26
        appendInstr(immWord(opOri, 5'd0, 5'd10, 16'd5));
        appendInstr(immWord(opOri, 5'd0, 5'd11, 16'd5));
        appendInstr(immWord(opBeq, 5'd10, 5'd11, 16'd3));
        appendInstr(immWord(opOri, 5'd0, 5'd12, 16'h0011));
        appendInstr(immWord(opSw, 5'd0, 5'd12, 16'h0300));
        appendInstr(immWord(opSw, 5'd0, 5'd12, 16'h0304));
        appendInstr(immWord(opSw, 5'd0, 5'd12, 16'h0118));
        appendInstr(immWord(opBne, 5'd10, 5'd11, 16'd2));
        appendInstr(immWord(opOri, 5'd0, 5'd13, 16'h0022));
        appendInstr(immWord(opSw, 5'd0, 5'd13, 16'h011c));
        addExpect(3, 32'h118, 32'h11);
        addExpect(3, 32'h11c, 32'h22);
        // Call to the routine at word 36 that returns to word 29
        appendInstr(jumpWord(opJal, resetPc + 32'd144));
        appendInstr(immWord(opOri, 5'd0, 5'd14, 16'h0033));
        appendInstr(immWord(opSw, 5'd0, 5'd14, 16'h0124));
        addExpect(4, 32'h120, resetPc + 32'd116);
        addExpect(4, 32'h124, 32'h33);
        // Register zero stays zero
        appendInstr(rTypeWord(5'd1, 5'd2, 5'd0, fnAddu));
        appendInstr(immWord(opOri, 5'd0, 5'd0, 16'h0055));
        appendInstr(immWord(opSw, 5'd0, 5'd0, 16'h0128));
        addExpect(6, 32'h128, 32'h0);
        // Spin on itself
        appendInstr(immWord(opBeq, 5'd0, 5'd0, 16'hFFFF));
        appendInstr(32'h0);
        appendInstr(32'h0);
        appendInstr(immWord(opSw, 5'd0, 5'd31, 16'h0120));
        appendInstr(rTypeWord(5'd31, 5'd0, 5'd0, fnJr));
        appendInstr(32'h0);
    endtask

    // Fetch port and load data answer right after the edge
    always @(posedge clk) begin
        #1;
        imemData = fetchWord(imemAddr);
        busDataOut = busRead ? dataMem[busAddress[11:2]] : '0;
    end

    always @(negedge clk) begin
        if (reset) begin
            if (busWrite !== 1'b0 || busRead !== 1'b0) begin
                strobeInReset = 1'b1;
            end
        end else begin
            if (cycle == 0) begin
                firstPc = imemAddr;
                firstEffPc = effectivePc;
            end
            if (busWrite) begin
                storeQ.push_back('{addr: busAddress, data: busDataIn});
                dataMem[busAddress[11:2]] = busDataIn;
                if (firstStoreCycle < 0) begin
                    firstStoreCycle = cycle;
                end
            end
            cycle++;
        end
    end

    initial begin
        storeEvent_t ev;
        expStore_t want;
        bit gotIt;
        word_t a;
        word_t b;
        void'($urandom(17));
        a = $urandom();
        b = $urandom();
        testName = '{"no stray stores", "dependent ALU chain", "load-use stall",
                     "branches and delay slots", "jal and jr", "reset state", "register zero"};
        for (int i = 0; i < 7; i++) begin
            testFails[i] = 0;
        end
        for (int i = 0; i < 1024; i++) begin
            dataMem[i] = fillWord(word_t'(i * 4));
        end
        buildProgram(a, b);

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < expTable.size(); i++) begin
            want = expTable[i];
            waitForStore(gotIt);
            confirm(gotIt, $sformatf("timed out waiting for a store to address %h", want.addr),
                    want.testNum);
            if (!gotIt) begin
                reportTest(want.testNum);
                break;
            end
            ev = storeQ.pop_front();
            compareWord("busAddress", ev.addr, want.addr, want.testNum);
            compareWord("busDataIn", ev.data, want.data, want.testNum);
            if (i == expTable.size() - 1 || expTable[i + 1].testNum != want.testNum) begin
                reportTest(want.testNum);
            end
        end

        compareWord("imemAddr", firstPc, resetPc, 5);
        compareWord("effectivePc", firstEffPc, resetPc, 5);
        confirm(!strobeInReset, "a bus strobe was raised during reset", 5);
        confirm(firstStoreCycle == firstSwCycle,
                $sformatf("first store reached the bus in cycle %0d instead of %0d",
                          firstStoreCycle, firstSwCycle), 5);
        reportTest(5);

        repeat (quietCycles) @(posedge clk);
        confirm(storeQ.size() == 0, "a store appeared after the last expected one", 0);
        reportTest(0);

        $display("%0d checks, %0d passed, %0d failed", checkCount, checkCount - failCount,
                 failCount);
        if (failCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
design/isaPkg.sv
design/pipePkg.sv
design/instructionFetch.sv
design/instructionDecoder.sv
design/registerFile.sv
design/operandForward.sv
design/pipelineCpu.sv
bench/pipelineCpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the pipelined CPU testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module pipelineCpuTb -o pipelineCpuTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/pipelineCpuTb > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "All tests passed" "$logFile"; then
    exit 0
fi
echo "Pass message not found in $logFile"
exit 1
